// ==== video_golden.txt ====
# W/R/E: hex address, hex data (R expects it, E expects pslverr and a read of 0)
# F: capture the next frame; P: decimal row, decimal column, hex 12-bit colour
W 000 0105
W 006 1202
W 008 010C
W 00E 0201
W 106 0303
W 12A 0A15
W 138 0B1C
W 13A 0D1D
W 150 0E28
W 152 0C29
W 15E 0F2F
W 202 00F0
W 200 0001
E 107 0FFF
E 010 5555
E 300 1234
E 204 0001
R 106 0303
R 000 0105
R 00E 0201
R 200 0001
R 202 00F0
F
P 0 0 A15
P 0 7 B1C
P 0 8 0F0
P 0 19 303
P 0 24 C29
P 9 0 D1D
P 9 3 0F0
P 9 30 E28
P 15 31 F2F
W 200 0000
F
P 0 0 0F0
P 9 30 0F0
P 15 31 0F0

// ==== project.f ====
video_pkg.sv
video_timer.sv
tile_vram.sv
tile_fetch_fsm.sv
line_buffer.sv
apb_decode.sv
palette_mixer.sv
video_top.sv
video_checker.sv
tb_video.sv

// ==== Makefile ====
obj_dir/Vtb_video: project.f $(wildcard *.sv)
	verilator --binary --timing --assert -f project.f --top-module tb_video -o Vtb_video

.PHONY: run clean

run: obj_dir/Vtb_video
	./obj_dir/Vtb_video +verilator+error+limit+100 | \
		awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== tb_video.sv ====
`timescale 1ns/100ps

module tb_video;

    localparam int frame_ns = video_pkg::h_total * video_pkg::v_total * 8;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic [11:0]                  paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [15:0]                  pwdata;
    logic [15:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         rom_cs;
    logic [video_pkg::rom_aw-1:0] rom_addr;
    logic [31:0]                  rom_data;
    logic                         rom_ok;
    logic                         hs;
    logic                         vs;
    logic                         lhbl_dly;
    logic                         lvbl_dly;
    logic [3:0]                   red;
    logic [3:0]                   green;
    logic [3:0]                   blue;

    logic [11:0] frame [0:video_pkg::v_visible-1][0:video_pkg::h_visible-1];
    string       golden [$];
    int          golden_lines = 0;
    int          rom_left;
    int          data_errors  = 0;
    int          flag_errors  = 0;
    int          color_errors = 0;
    int          count_errors = 0;
    int          file_errors  = 0;

    video_top UUT (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .paddr    ( paddr    ),
        .psel     ( psel     ),
        .penable  ( penable  ),
        .pwrite   ( pwrite   ),
        .pwdata   ( pwdata   ),
        .prdata   ( prdata   ),
        .pready   ( pready   ),
        .pslverr  ( pslverr  ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    always #4 clk = ~clk;

    // Nibble k of a ROM word is code plus row plus k modulo 16
    // Only the low code bits matter for that sum
    function automatic logic [31:0] rom_word(input logic [video_pkg::rom_aw-1:0] addr);
        logic [31:0] word;
        for (int k = 0; k < 8; k++) begin
            word[k*4 +: 4] = 4'(addr[6:3] + addr[2:0] + k);
        end
        return word;
    endfunction

    // ROM answers 1 to 4 cycles after it sees the request
    always @(posedge clk) begin
        if (!rst_n) begin
            rom_ok <= 1'b0;
            rom_left = 0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_cs && !rom_ok) begin
                if (rom_left == 0) begin
                    rom_left = 1 + int'($urandom % 4);
                end
                rom_left = rom_left - 1;
                if (rom_left == 0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_addr);
                end
            end
        end
    end

    task automatic check_data(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    task automatic check_color(input string name, input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            color_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            count_errors++;
        end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [15:0] data, output logic [15:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // One frame from vs rise to vs rise
    // Every line in it is fetched after the earlier writes
    task automatic capture_frame();
        int   x;
        int   y;
        int   pixels;
        int   clocks;
        int   vs_clocks;
        int   hs_pulses;
        int   vs_pulses;
        logic visible;
        logic visible_q;
        logic hs_q;
        logic vs_q;
        x         = 0;
        y         = 0;
        pixels    = 0;
        clocks    = 0;
        vs_clocks = 0;
        hs_pulses = 0;
        vs_pulses = 0;
        @(posedge vs);
        @(negedge clk);
        visible_q = 1'b0;
        hs_q      = hs;
        vs_q      = vs;
        while (vs_pulses == 0) begin
            @(negedge clk);
            clocks++;
            if (vs) begin
                vs_clocks++;
            end
            visible = lhbl_dly && lvbl_dly;
            if (visible) begin
                if (x < video_pkg::h_visible && y < video_pkg::v_visible) begin
                    frame[y][x] = {red, green, blue};
                end
                x++;
                pixels++;
            end else if (visible_q) begin
                x = 0;
                y++;
            end
            if (hs && !hs_q) begin
                hs_pulses++;
            end
            if (vs && !vs_q) begin
                vs_pulses++;
            end
            visible_q = visible;
            hs_q      = hs;
            vs_q      = vs;
        end
        check_count("visible pixels", pixels, video_pkg::h_visible * video_pkg::v_visible);
        check_count("visible lines", y, video_pkg::v_visible);
        check_count("hs pulses", hs_pulses, video_pkg::v_total);
        check_count("frame clocks", clocks, video_pkg::h_total * video_pkg::v_total);
        check_count("vs clocks", vs_clocks,
                    (video_pkg::vs_end - video_pkg::vs_start + 1) * video_pkg::h_total);
    endtask

    initial begin
        int          fd;
        int          n;
        int          row;
        int          col;
        int          asserts;
        string       text;
        logic [7:0]  kind;
        logic [11:0] addr;
        logic [15:0] data;
        logic [15:0] rdata;
        logic        err;
        logic [11:0] color;
        void'($urandom(57));
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        fd = $fopen("video_golden.txt", "r");
        if (fd == 0) begin
            $display("The golden file video_golden.txt could not be opened");
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 1 && text.getc(0) != "#") begin
                    golden.push_back(text);
                end
            end
            $fclose(fd);
        end
        golden_lines = golden.size();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        foreach (golden[i]) begin
            n = $sscanf(golden[i], "%c", kind);
            case (kind)
                "W": begin
                    n = $sscanf(golden[i], "%c %h %h", kind, addr, data);
                    apb_access(1'b1, addr, data, rdata, err);
                    check_flag("pslverr", err, 1'b0);
                end
                "R": begin
                    n = $sscanf(golden[i], "%c %h %h", kind, addr, data);
                    apb_access(1'b0, addr, 16'h0000, rdata, err);
                    check_flag("pslverr", err, 1'b0);
                    check_data("prdata", rdata, data);
                end
                "E": begin
                    n = $sscanf(golden[i], "%c %h %h", kind, addr, data);
                    apb_access(1'b1, addr, data, rdata, err);
                    check_flag("pslverr", err, 1'b1);
                    apb_access(1'b0, addr, 16'h0000, rdata, err);
                    check_flag("pslverr", err, 1'b1);
                    check_data("prdata", rdata, 16'h0000);
                end
                "F": begin
                    capture_frame();
                end
                "P": begin
                    n = $sscanf(golden[i], "%c %d %d %h", kind, row, col, color);
                    if (row >= video_pkg::v_visible || col >= video_pkg::h_visible) begin
                        $display("Golden line %0d names a pixel outside the screen", i + 1);
                        file_errors++;
                    end else begin
                        check_color($sformatf("rgb[%0d][%0d]", row, col), frame[row][col], color);
                    end
                end
                default: begin
                    $display("Golden line %0d has a kind that is not known", i + 1);
                    file_errors++;
                end
            endcase
        end
        asserts = UUT.u_checker.rom_errors + UUT.u_checker.blank_errors
                + UUT.u_checker.ready_errors;
        $display("Errors: prdata %0d, pslverr %0d, pixel %0d, raster %0d, file %0d, assert %0d",
                 data_errors, flag_errors, color_errors, count_errors, file_errors, asserts);
        if (data_errors + flag_errors + color_errors + count_errors + file_errors
            + asserts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Each golden line takes at most two frames
    initial begin
        wait (golden_lines > 0);
        #(golden_lines * 2 * frame_ns + 4 * frame_ns);
        $display("Watchdog expired before the golden file was played to its end");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== video_checker.sv ====
`timescale 1ns/100ps

module video_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          rom_cs,
    input logic [video_pkg::rom_aw-1:0]  rom_addr,
    input logic                          rom_ok,
    input logic                          pready,
    input logic                          lhbl_dly,
    input logic                          lvbl_dly,
    input logic [3:0]                    red,
    input logic [3:0]                    green,
    input logic [3:0]                    blue
);

    int rom_errors   = 0;
    int blank_errors = 0;
    int ready_errors = 0;

    // ROM request holds until the ROM answers
    rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rom_cs && !rom_ok) |=> (rom_cs && $stable(rom_addr)))
    else begin
        $error("rom_cs dropped or rom_addr moved before rom_ok");
        rom_errors++;
    end

    // Blanked pixels are black
    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (!lhbl_dly || !lvbl_dly) |-> ({red, green, blue} == 12'd0))
    else begin
        $error("colour output not black during blanking");
        blank_errors++;
    end

    // Zero wait state APB slave
    ready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else begin
        $error("pready went low");
        ready_errors++;
    end

endmodule

bind video_top video_checker u_checker (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .rom_cs   ( rom_cs   ),
    .rom_addr ( rom_addr ),
    .rom_ok   ( rom_ok   ),
    .pready   ( pready   ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     )
);

// ==== video_top.sv ====
`timescale 1ns/100ps

module video_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [11:0]                   paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [15:0]                   pwdata,
    output logic [15:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          rom_cs,
    output logic [video_pkg::rom_aw-1:0]  rom_addr,
    input  logic [31:0]                   rom_data,
    input  logic                          rom_ok,
    output logic                          hs,
    output logic                          vs,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly,
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue
);

    logic [5:0]  hdump;
    logic [4:0]  vdump;
    logic        lhbl;
    logic        lvbl;
    logic        vram_we;
    logic        pal_we;
    logic        ctrl_we;
    logic        back_we;
    logic        reg_sel;
    logic [6:0]  reg_idx;
    logic [15:0] reg_wdata;
    logic [15:0] vram_rdata;
    logic [15:0] mix_rdata;
    logic [2:0]  vram_fetch_idx;
    logic [15:0] vram_fetch_data;
    logic        wr_en;
    logic [1:0]  wr_addr;
    logic [31:0] wr_pixels;
    logic [2:0]  wr_pal;
    logic [6:0]  rd_color;

    video_timer u_timer (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .hdump ( hdump ),
        .vdump ( vdump ),
        .lhbl  ( lhbl  ),
        .lvbl  ( lvbl  ),
        .hs    ( hs    ),
        .vs    ( vs    )
    );

    apb_decode u_apb (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .paddr      ( paddr      ),
        .psel       ( psel       ),
        .penable    ( penable    ),
        .pwrite     ( pwrite     ),
        .pwdata     ( pwdata     ),
        .prdata     ( prdata     ),
        .pready     ( pready     ),
        .pslverr    ( pslverr    ),
        .vram_we    ( vram_we    ),
        .pal_we     ( pal_we     ),
        .ctrl_we    ( ctrl_we    ),
        .back_we    ( back_we    ),
        .reg_sel    ( reg_sel    ),
        .idx        ( reg_idx    ),
        .wdata      ( reg_wdata  ),
        .vram_rdata ( vram_rdata ),
        .mix_rdata  ( mix_rdata  )
    );

    tile_vram u_vram (
        .clk        ( clk             ),
        .rst_n      ( rst_n           ),
        .we         ( vram_we         ),
        .idx        ( reg_idx[2:0]    ),
        .wdata      ( reg_wdata       ),
        .rdata      ( vram_rdata      ),
        .fetch_idx  ( vram_fetch_idx  ),
        .fetch_data ( vram_fetch_data )
    );

    tile_fetch_fsm u_fetch (
        .clk             ( clk             ),
        .rst_n           ( rst_n           ),
        .hdump           ( hdump           ),
        .vdump           ( vdump           ),
        .vram_fetch_idx  ( vram_fetch_idx  ),
        .vram_fetch_data ( vram_fetch_data ),
        .rom_cs          ( rom_cs          ),
        .rom_addr        ( rom_addr        ),
        .rom_data        ( rom_data        ),
        .rom_ok          ( rom_ok          ),
        .wr_en           ( wr_en           ),
        .wr_addr         ( wr_addr         ),
        .wr_pixels       ( wr_pixels       ),
        .wr_pal          ( wr_pal          )
    );

    // Halves swap at the first pixel of each line
    line_buffer u_linebuf (
        .clk       ( clk            ),
        .rst_n     ( rst_n          ),
        .swap      ( hdump == 6'd0  ),
        .wr_en     ( wr_en          ),
        .wr_addr   ( wr_addr        ),
        .wr_pixels ( wr_pixels      ),
        .wr_pal    ( wr_pal         ),
        .hdump     ( hdump          ),
        .rd_color  ( rd_color       )
    );

    palette_mixer u_mixer (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pal_we   ( pal_we    ),
        .ctrl_we  ( ctrl_we   ),
        .back_we  ( back_we   ),
        .reg_sel  ( reg_sel   ),
        .idx      ( reg_idx   ),
        .wdata    ( reg_wdata ),
        .rd_color ( rd_color  ),
        .lhbl     ( lhbl      ),
        .lvbl     ( lvbl      ),
        .rdata    ( mix_rdata ),
        .red      ( red       ),
        .green    ( green     ),
        .blue     ( blue      ),
        .lhbl_dly ( lhbl_dly  ),
        .lvbl_dly ( lvbl_dly  )
    );

endmodule

// ==== palette_mixer.sv ====
`timescale 1ns/100ps

module palette_mixer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pal_we,
    input  logic        ctrl_we,
    input  logic        back_we,
    input  logic        reg_sel,
    input  logic [6:0]  idx,
    input  logic [15:0] wdata,
    input  logic [6:0]  rd_color,
    input  logic        lhbl,
    input  logic        lvbl,
    output logic [15:0] rdata,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly
);

    localparam int cw = video_pkg::color_w;

    // Colour words are RGB, red in the top nibble
    logic [cw-1:0] pal_ram [0:127];
    logic          layer_en;
    logic [cw-1:0] back_color;
    logic          lhbl_d1;
    logic          lvbl_d1;
    logic [cw-1:0] pix_color;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[idx] <= wdata[cw-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_en   <= 1'b0;
            back_color <= '0;
        end else begin
            if (ctrl_we) begin
                layer_en <= wdata[video_pkg::layer_en_bit];
            end
            if (back_we) begin
                back_color <= wdata[cw-1:0];
            end
        end
    end

    always_comb begin
        if (!reg_sel) begin
            rdata = {{(16-cw){1'b0}}, pal_ram[idx]};
        end else if (idx[0]) begin
            rdata = {{(16-cw){1'b0}}, back_color};
        end else begin
            rdata = {15'd0, layer_en};
        end
    end

    // Transparent pixel or disabled layer shows the back colour
    assign pix_color = (rd_color[3:0] == 4'd0 || !layer_en) ? back_color : pal_ram[rd_color];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            {red, green, blue} <= '0;
        end else begin
            lhbl_d1  <= lhbl;
            lvbl_d1  <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            {red, green, blue} <= (lhbl_d1 && lvbl_d1) ? pix_color : '0;
        end
    end

endmodule

// ==== apb_decode.sv ====
`timescale 1ns/100ps

module apb_decode (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        vram_we,
    output logic        pal_we,
    output logic        ctrl_we,
    output logic        back_we,
    output logic        reg_sel,
    output logic [6:0]  idx,
    output logic [15:0] wdata,
    input  logic [15:0] vram_rdata,
    input  logic [15:0] mix_rdata
);

    logic access;
    logic hit_vram;
    logic hit_pal;
    logic hit_ctrl;
    logic hit_back;
    logic bad;
    logic sel_vram_q;
    logic sel_pal_q;
    logic sel_ctrl_q;
    logic sel_back_q;
    logic err_q;

    assign access = psel & penable;

    always_comb begin
        hit_vram = (paddr - video_pkg::vram_base) < (video_pkg::vram_end - video_pkg::vram_base);
        hit_pal  = (paddr - video_pkg::pal_base) < (video_pkg::pal_end - video_pkg::pal_base);
        hit_ctrl = paddr == video_pkg::ctrl_addr;
        hit_back = paddr == video_pkg::back_addr;
        // Odd byte addresses are never valid on this 16-bit port
        bad = paddr[0] | ~(hit_vram | hit_pal | hit_ctrl | hit_back);
    end

    // Decode is captured in the setup phase and used in the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_vram_q <= 1'b0;
            sel_pal_q  <= 1'b0;
            sel_ctrl_q <= 1'b0;
            sel_back_q <= 1'b0;
            err_q      <= 1'b0;
        end else if (psel && !penable) begin
            sel_vram_q <= hit_vram & ~bad;
            sel_pal_q  <= hit_pal & ~bad;
            sel_ctrl_q <= hit_ctrl & ~bad;
            sel_back_q <= hit_back & ~bad;
            err_q      <= bad;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access & err_q;

    assign vram_we = access & pwrite & sel_vram_q;
    assign pal_we  = access & pwrite & sel_pal_q;
    assign ctrl_we = access & pwrite & sel_ctrl_q;
    assign back_we = access & pwrite & sel_back_q;

    // Register reads use idx[0] to pick ctrl or back
    assign reg_sel = sel_ctrl_q | sel_back_q;
    assign idx     = paddr[7:1];
    assign wdata   = pwdata;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (sel_vram_q) begin
                prdata = vram_rdata;
            end else if (sel_pal_q || reg_sel) begin
                prdata = mix_rdata;
            end
        end
    end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        swap,
    input  logic        wr_en,
    input  logic [1:0]  wr_addr,
    input  logic [31:0] wr_pixels,
    input  logic [2:0]  wr_pal,
    input  logic [5:0]  hdump,
    output logic [6:0]  rd_color
);

    // Each entry holds one tile slice: palette over 8 pixels
    logic [34:0] slice [0:1][0:3];
    logic        bank;
    logic        rd_bank;
    logic [34:0] rd_slice;

    // Read side flips in the swap cycle itself so pixel 0 is from the new line
    assign rd_bank  = bank ^ swap;
    assign rd_slice = slice[rd_bank][hdump[4:3]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank     <= 1'b0;
            rd_color <= '0;
        end else begin
            bank     <= rd_bank;
            rd_color <= {rd_slice[34:32], rd_slice[hdump[2:0]*video_pkg::pix_w +: video_pkg::pix_w]};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slice[~bank][wr_addr] <= {wr_pal, wr_pixels};
        end
    end

endmodule

// ==== tile_fetch_fsm.sv ====
`timescale 1ns/100ps

module tile_fetch_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [5:0]                    hdump,
    input  logic [4:0]                    vdump,
    output logic [2:0]                    vram_fetch_idx,
    input  logic [15:0]                   vram_fetch_data,
    output logic                          rom_cs,
    output logic [video_pkg::rom_aw-1:0]  rom_addr,
    input  logic [31:0]                   rom_data,
    input  logic                          rom_ok,
    output logic                          wr_en,
    output logic [1:0]                    wr_addr,
    output logic [31:0]                   wr_pixels,
    output logic [2:0]                    wr_pal
);

    logic [1:0]  state;
    logic [1:0]  col;
    logic [4:0]  line;
    logic [2:0]  tile_pal;
    logic        tile_hflip;
    logic [31:0] flipped;
    logic        done;

    // Tilemap row comes from bit 3 of the line, column from the walk
    assign vram_fetch_idx = {line[3], col};
    assign done = (state == video_pkg::st_write) && (col == 2'(video_pkg::tile_cols - 1));

    // Nibble order reversed for horizontally flipped tiles
    always_comb begin
        for (int k = 0; k < video_pkg::tile_px; k++) begin
            flipped[k*video_pkg::pix_w +: video_pkg::pix_w] =
                rom_data[(video_pkg::tile_px-1-k)*video_pkg::pix_w +: video_pkg::pix_w];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= video_pkg::st_idle;
            col    <= '0;
            line   <= '0;
            rom_cs <= 1'b0;
            wr_en  <= 1'b0;
        end else begin
            case (state)
                video_pkg::st_idle: begin
                    // Start of horizontal blanking, prepare the next line
                    if (hdump == 6'(video_pkg::h_visible)) begin
                        if (vdump == 5'(video_pkg::v_total - 1)) begin
                            line <= '0;
                        end else begin
                            line <= vdump + 5'd1;
                        end
                        col   <= '0;
                        state <= video_pkg::st_read_map;
                    end
                end
                video_pkg::st_read_map: begin
                    rom_cs <= 1'b1;
                    state  <= video_pkg::st_rom_wait;
                end
                video_pkg::st_rom_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        wr_en  <= 1'b1;
                        state  <= video_pkg::st_write;
                    end
                end
                default: begin
                    wr_en <= 1'b0;
                    if (done) begin
                        state <= video_pkg::st_idle;
                    end else begin
                        col   <= col + 2'd1;
                        state <= video_pkg::st_read_map;
                    end
                end
            endcase
        end
    end

    // Tile attributes and pixel data
    always_ff @(posedge clk) begin
        if (state == video_pkg::st_read_map) begin
            rom_addr   <= {vram_fetch_data[video_pkg::code_msb:video_pkg::code_lsb], line[2:0]};
            tile_pal   <= vram_fetch_data[video_pkg::pal_msb:video_pkg::pal_lsb];
            tile_hflip <= vram_fetch_data[video_pkg::hflip_bit];
        end
        if (state == video_pkg::st_rom_wait && rom_ok) begin
            wr_pixels <= tile_hflip ? flipped : rom_data;
            wr_pal    <= tile_pal;
            wr_addr   <= col;
        end
    end

endmodule

// ==== tile_vram.sv ====
`timescale 1ns/100ps

module tile_vram (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [2:0]  idx,
    input  logic [15:0] wdata,
    output logic [15:0] rdata,
    input  logic [2:0]  fetch_idx,
    output logic [15:0] fetch_data
);

    localparam int depth = video_pkg::tile_cols * video_pkg::tile_rows;

    logic [15:0] map [0:depth-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                map[i] <= '0;
            end
        end else if (we) begin
            map[idx] <= wdata;
        end
    end

    // Both ports read combinationally
    assign rdata      = map[idx];
    assign fetch_data = map[fetch_idx];

endmodule

// ==== video_timer.sv ====
`timescale 1ns/100ps

module video_timer (
    input  logic       clk,
    input  logic       rst_n,
    output logic [5:0] hdump,
    output logic [4:0] vdump,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs
);

    logic [5:0] h_next;
    logic [4:0] v_next;

    // Next raster position, decodes below are taken from it so that
    // blanking and sync line up with the counters
    always_comb begin
        h_next = hdump + 6'd1;
        v_next = vdump;
        if (hdump == 6'(video_pkg::h_total - 1)) begin
            h_next = '0;
            if (vdump == 5'(video_pkg::v_total - 1)) begin
                v_next = '0;
            end else begin
                v_next = vdump + 5'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else begin
            hdump <= h_next;
            vdump <= v_next;
            lhbl  <= h_next < 6'(video_pkg::h_visible);
            lvbl  <= v_next < 5'(video_pkg::v_visible);
            hs    <= h_next >= 6'(video_pkg::hs_start) && h_next <= 6'(video_pkg::hs_end);
            vs    <= v_next >= 5'(video_pkg::vs_start) && v_next <= 5'(video_pkg::vs_end);
        end
    end

endmodule

// ==== video_pkg.sv ====
package video_pkg;

    // Raster, in clocks per line and lines per frame
    localparam int h_total   = 64;
    localparam int h_visible = 32;
    localparam int hs_start  = 40;
    localparam int hs_end    = 47;
    localparam int v_total   = 24;
    localparam int v_visible = 16;
    localparam int vs_start  = 18;
    localparam int vs_end    = 19;

    // Tile geometry
    localparam int tile_cols = 4;
    localparam int tile_rows = 2;
    localparam int tile_px   = 8;
    localparam int pix_w     = 4;

    // ROM address is code * 8 + row in the tile
    localparam int rom_aw = 11;

    // APB byte address map, end addresses are exclusive
    localparam logic [11:0] vram_base = 12'h000;
    localparam logic [11:0] vram_end  = 12'h010;
    localparam logic [11:0] pal_base  = 12'h100;
    localparam logic [11:0] pal_end   = 12'h200;
    localparam logic [11:0] ctrl_addr = 12'h200;
    localparam logic [11:0] back_addr = 12'h202;

    // Register and tile entry fields
    localparam int layer_en_bit = 0;
    localparam int color_w      = 12;
    localparam int code_lsb     = 0;
    localparam int code_msb     = 7;
    localparam int pal_lsb      = 8;
    localparam int pal_msb      = 10;
    localparam int hflip_bit    = 12;

    // Fetch FSM states
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_read_map = 2'd1;
    localparam logic [1:0] st_rom_wait = 2'd2;
    localparam logic [1:0] st_write    = 2'd3;

endpackage
